// ==== dir_pkg.sv ====
// shared constants and types for the coherence directory segment
// address split, coherence states, command opcodes and row layout
// import with a wildcard inside the module body

package dir_pkg;

  // address layout: tag | set | block offset
  localparam int PADDR_W        = 20;
  localparam int BLOCK_OFFSET_W = 4;
  localparam int SET_W          = 3;
  localparam int SETS           = 8;
  localparam int TAG_W          = PADDR_W - BLOCK_OFFSET_W - SET_W;

  // tracked cache geometry
  localparam int ASSOC = 4;
  localparam int WAY_W = 2;

  // two lce tag sets share one ram row, the row logic relies on this
  localparam int TAG_SETS_PER_ROW = 2;

  // lce id field in a request, wide enough for any supported lce count
  localparam int LCE_ID_W = 8;

  typedef enum logic [1:0] {
    e_coh_invalid   = 2'd0,
    e_coh_shared    = 2'd1,
    e_coh_exclusive = 2'd2,
    e_coh_modified  = 2'd3
  } coh_state_e;

  // rdw and rde are reads, the rest write in one cycle
  typedef enum logic [2:0] {
    e_cmd_rdw = 3'd0,
    e_cmd_rde = 3'd1,
    e_cmd_wde = 3'd2,
    e_cmd_wds = 3'd3,
    e_cmd_clr = 3'd4
  } dir_cmd_e;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    coh_state_e       state;
  } dir_entry_s;

  // [tag set][way], tag set 0 is the even lce of the row
  typedef dir_entry_s [TAG_SETS_PER_ROW-1:0][ASSOC-1:0] dir_row_t;

  typedef struct packed {
    dir_cmd_e            cmd;
    logic [LCE_ID_W-1:0] lce;
    logic [WAY_W-1:0]    way;
    logic [PADDR_W-1:0]  addr;
    coh_state_e          coh_state;
  } dir_req_s;

  // tag compare result of one lce tag set
  typedef struct packed {
    logic             hit;
    logic [WAY_W-1:0] way;
    coh_state_e       state;
  } dir_hit_s;

endpackage

// ==== dir_ram.sv ====
// single-port directory row ram, synchronous read, bitwise write mask
// one access per cycle: write when w_i is set, else read into data_o

module dir_ram #(
  parameter int num_lce_p = 4,
  localparam int rows_lp = ((num_lce_p + 1) / 2) * dir_pkg::SETS,
  localparam int addr_w_lp = $clog2(rows_lp)
) (
  input  logic                 clk_i,
  input  logic                 v_i,
  input  logic                 w_i,
  input  logic [addr_w_lp-1:0] addr_i,
  input  dir_pkg::dir_row_t    w_mask_i,
  input  dir_pkg::dir_row_t    w_data_i,
  output dir_pkg::dir_row_t    data_o
);

  import dir_pkg::*;

  // row storage, contents cleared by the init walk after reset
  dir_row_t mem [rows_lp];

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        // only masked bits take the new data
        mem[addr_i] <= (mem[addr_i] & ~w_mask_i) | (w_data_i & w_mask_i);
      end else begin
        data_o <= mem[addr_i];
      end
    end
  end

  // read data holds across write cycles and idle cycles

  // row count is not always a power of two, e.g. odd lce counts
  a_addr_range: assert property (
    @(posedge clk_i) v_i |-> (int'(addr_i) < rows_lp)
  ) else $error("directory ram address %0d out of range", addr_i);

endmodule

// ==== dir_row_counter.sv ====
// up counter used to walk directory rows
// clear beats increment, both take effect at the next edge

module dir_row_counter #(
  parameter int max_p = 8,
  localparam int width_lp = $clog2(max_p + 1)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                clear_i,
  input  logic                up_i,
  output logic [width_lp-1:0] count_o
);

  logic [width_lp-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (clear_i) begin
      count_r <= '0;
    end else if (up_i) begin
      count_r <= count_r + 1'b1;
    end
  end

  assign count_o = count_r;

  // the fsm must clear before the walk runs past the last row
  a_count_max: assert property (
    @(posedge clk_i) disable iff (reset_i) int'(count_o) <= max_p
  ) else $error("row counter passed max %0d", max_p);

endmodule

// ==== dir_sharers_gather.sv ====
// tag compare on each ram row and the sharers result registers
// full reads fill two lce slots per row, entry reads fill slot 0
// sharers_v_o rises one cycle after the last row or entry is taken

module dir_sharers_gather #(
  parameter int num_lce_p = 4,
  localparam int lce_w_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  dir_pkg::dir_row_t                            row_i,
  input  logic [dir_pkg::TAG_SETS_PER_ROW-1:0]         row_v_i,
  input  logic [lce_w_lp-1:0]                          row_base_i,
  input  logic [lce_w_lp-1:0]                          lce_i,
  input  logic [dir_pkg::WAY_W-1:0]                    way_i,
  input  logic [dir_pkg::TAG_W-1:0]                    tag_i,
  input  logic                                         clear_i,
  input  logic                                         entry_sel_i,
  input  logic                                         done_i,
  output logic                                         sharers_v_o,
  output logic [num_lce_p-1:0]                         sharers_hits_o,
  output logic [num_lce_p-1:0][dir_pkg::WAY_W-1:0]     sharers_ways_o,
  output dir_pkg::coh_state_e [num_lce_p-1:0]          sharers_states_o,
  output logic                                         entry_addr_v_o,
  output logic [dir_pkg::PADDR_W-1:0]                  entry_addr_o
);

  import dir_pkg::*;

  dir_hit_s [TAG_SETS_PER_ROW-1:0] cmp;
  dir_entry_s                      sel_entry;
  logic                            sel_hit;

  logic                            fin_r;
  logic                            sharers_v_r;
  logic [num_lce_p-1:0]            hits_r;
  logic [num_lce_p-1:0][WAY_W-1:0] ways_r;
  coh_state_e [num_lce_p-1:0]      states_r;

  // per tag set: lowest valid way with a matching tag
  always_comb begin
    for (int s = 0; s < TAG_SETS_PER_ROW; s++) begin
      cmp[s] = '{hit: 1'b0, way: '0, state: e_coh_invalid};
      // scan downward so the lowest way wins
      for (int w = ASSOC - 1; w >= 0; w--) begin
        if (row_i[s][w].tag == tag_i && row_i[s][w].state != e_coh_invalid) begin
          cmp[s].hit   = 1'b1;
          cmp[s].way   = WAY_W'(w);
          cmp[s].state = row_i[s][w].state;
        end
      end
    end
  end

  // single entry read, tag set picked by the lce parity
  assign sel_entry = row_i[lce_i[0]][way_i];
  assign sel_hit   = (sel_entry.tag == tag_i) && (sel_entry.state != e_coh_invalid);

  assign entry_addr_v_o = entry_sel_i;
  assign entry_addr_o   = {sel_entry.tag, {(PADDR_W - TAG_W){1'b0}}};

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      for (int j = 0; j < num_lce_p; j++) begin
        hits_r[j]   <= 1'b0;
        ways_r[j]   <= '0;
        states_r[j] <= e_coh_invalid;
      end
    end else if (entry_sel_i) begin
      hits_r[0]   <= sel_hit;
      ways_r[0]   <= way_i;
      states_r[0] <= sel_entry.state;
    end else begin
      // slot j belongs to the row whose base is j rounded down to even
      for (int j = 0; j < num_lce_p; j++) begin
        if (row_v_i[j % 2] && int'(row_base_i) == (j - (j % 2))) begin
          hits_r[j]   <= cmp[j % 2].hit;
          ways_r[j]   <= cmp[j % 2].way;
          states_r[j] <= cmp[j % 2].state;
        end
      end
    end
  end

  // valid lags the last register update by one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fin_r       <= 1'b0;
      sharers_v_r <= 1'b0;
    end else begin
      fin_r <= done_i | entry_sel_i;
      if (clear_i) begin
        sharers_v_r <= 1'b0;
      end else if (fin_r) begin
        sharers_v_r <= 1'b1;
      end
    end
  end

  assign sharers_v_o      = sharers_v_r;
  assign sharers_hits_o   = hits_r;
  assign sharers_ways_o   = ways_r;
  assign sharers_states_o = states_r;

endmodule

// ==== dir_ctrl_fsm.sv ====
// directory control: decodes requests and drives ram, counter and gatherer
// after reset walks every row once to clear it, then serves commands
// writes finish at the accepting edge, reads hold busy_o until done

module dir_ctrl_fsm #(
  parameter int num_lce_p = 4,
  localparam int rows_per_set_lp = (num_lce_p + 1) / 2,
  localparam int rows_lp = rows_per_set_lp * dir_pkg::SETS,
  localparam int row_addr_w_lp = $clog2(rows_lp),
  localparam int cnt_w_lp = $clog2(rows_lp + 1),
  localparam int lce_w_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 req_v_i,
  input  dir_pkg::dir_req_s                    req_i,
  output logic                                 busy_o,
  output logic                                 ram_v_o,
  output logic                                 ram_w_o,
  output logic [row_addr_w_lp-1:0]             ram_addr_o,
  output dir_pkg::dir_row_t                    ram_w_mask_o,
  output dir_pkg::dir_row_t                    ram_w_data_o,
  output logic                                 cnt_clr_o,
  output logic                                 cnt_inc_o,
  input  logic [cnt_w_lp-1:0]                  cnt_i,
  output logic                                 clear_o,
  output logic [dir_pkg::TAG_SETS_PER_ROW-1:0] row_v_o,
  output logic [lce_w_lp-1:0]                  row_base_o,
  output logic                                 entry_sel_o,
  output logic                                 done_o,
  output logic [lce_w_lp-1:0]                  lce_o,
  output logic [dir_pkg::WAY_W-1:0]            way_o,
  output logic [dir_pkg::TAG_W-1:0]            tag_o
);

  import dir_pkg::*;

  typedef enum logic [2:0] {
    e_st_reset, e_st_init, e_st_ready, e_st_read_full, e_st_read_entry
  } fsm_state_e;

  // row stride between the rows of one set
  localparam logic [row_addr_w_lp-1:0] set_step_lp = row_addr_w_lp'(SETS);
  localparam logic [cnt_w_lp-1:0] init_end_lp = cnt_w_lp'(rows_lp);
  localparam logic [cnt_w_lp-1:0] last_row_lp = cnt_w_lp'(rows_per_set_lp - 1);

  fsm_state_e                     state_r, state_n;
  logic [TAG_SETS_PER_ROW-1:0]    row_v_r, row_v_n;
  logic [row_addr_w_lp-1:0]       row_addr_r, row_addr_n;
  logic [lce_w_lp-1:0]            lce_r;
  logic [WAY_W-1:0]               way_r;
  logic [TAG_W-1:0]               tag_r;
  logic                           accept;
  logic [SET_W-1:0]               req_set;
  logic [TAG_W-1:0]               req_tag;
  logic [row_addr_w_lp-1:0]       entry_row;

  // valid tag sets of a row, odd lce counts leave the last row half used
  function automatic logic [1:0] row_mask(input int row);
    row_mask = {((2 * row) + 1) < num_lce_p, 1'b1};
  endfunction

  assign accept    = (state_r == e_st_ready) && req_v_i;
  assign req_set   = req_i.addr[BLOCK_OFFSET_W +: SET_W];
  assign req_tag   = req_i.addr[BLOCK_OFFSET_W + SET_W +: TAG_W];
  // row = (lce / 2) * SETS + set
  assign entry_row = row_addr_w_lp'(req_i.lce[LCE_ID_W-1:1] * SETS + req_set);

  always_comb begin
    state_n      = state_r;
    row_v_n      = '0;
    row_addr_n   = row_addr_r;
    busy_o       = 1'b0;
    ram_v_o      = 1'b0;
    ram_w_o      = 1'b0;
    ram_addr_o   = '0;
    ram_w_mask_o = '0;
    ram_w_data_o = '0;
    cnt_clr_o    = 1'b0;
    cnt_inc_o    = 1'b0;
    clear_o      = 1'b0;
    entry_sel_o  = 1'b0;
    done_o       = 1'b0;
    case (state_r)
      e_st_reset: begin
        cnt_clr_o = 1'b1;
        state_n   = e_st_init;
      end
      e_st_init: begin
        busy_o = 1'b1;
        // one extra cycle after the last row write
        if (cnt_i == init_end_lp) begin
          cnt_clr_o = 1'b1;
          state_n   = e_st_ready;
        end else begin
          ram_v_o      = 1'b1;
          ram_w_o      = 1'b1;
          ram_addr_o   = row_addr_w_lp'(cnt_i);
          ram_w_mask_o = '1;
          cnt_inc_o    = 1'b1;
        end
      end
      e_st_ready: begin
        if (req_v_i) begin
          // any accepted request drops the old sharers result
          clear_o = 1'b1;
          case (req_i.cmd)
            e_cmd_rdw: begin
              ram_v_o    = 1'b1;
              ram_addr_o = row_addr_w_lp'(req_set);
              row_addr_n = row_addr_w_lp'(req_set) + set_step_lp;
              row_v_n    = row_mask(0);
              cnt_clr_o  = 1'b1;
              state_n    = e_st_read_full;
            end
            e_cmd_rde: begin
              ram_v_o    = 1'b1;
              ram_addr_o = entry_row;
              state_n    = e_st_read_entry;
            end
            e_cmd_wde: begin
              ram_v_o    = 1'b1;
              ram_w_o    = 1'b1;
              ram_addr_o = entry_row;
              ram_w_mask_o[req_i.lce[0]][req_i.way]       = '1;
              ram_w_data_o[req_i.lce[0]][req_i.way].tag   = req_tag;
              ram_w_data_o[req_i.lce[0]][req_i.way].state = req_i.coh_state;
            end
            e_cmd_wds: begin
              ram_v_o    = 1'b1;
              ram_w_o    = 1'b1;
              ram_addr_o = entry_row;
              // state bits only, tag untouched
              ram_w_mask_o[req_i.lce[0]][req_i.way].state = coh_state_e'(2'b11);
              ram_w_data_o[req_i.lce[0]][req_i.way].state = req_i.coh_state;
            end
            e_cmd_clr: begin
              // whole row, so both lces of the pair
              ram_v_o      = 1'b1;
              ram_w_o      = 1'b1;
              ram_addr_o   = entry_row;
              ram_w_mask_o = '1;
            end
            default: begin
              state_n = e_st_ready;
            end
          endcase
        end
      end
      e_st_read_full: begin
        busy_o = 1'b1;
        if (cnt_i == last_row_lp) begin
          done_o    = 1'b1;
          cnt_clr_o = 1'b1;
          state_n   = e_st_ready;
        end else begin
          // fetch the next row of the set while this one is compared
          ram_v_o    = 1'b1;
          ram_addr_o = row_addr_r;
          row_addr_n = row_addr_r + set_step_lp;
          row_v_n    = row_mask(int'(cnt_i) + 1);
          cnt_inc_o  = 1'b1;
        end
      end
      e_st_read_entry: begin
        busy_o      = 1'b1;
        entry_sel_o = 1'b1;
        state_n     = e_st_ready;
      end
      default: begin
        state_n = e_st_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_st_reset;
      row_v_r <= '0;
    end else begin
      state_r <= state_n;
      row_v_r <= row_v_n;
    end
  end

  // request fields held for the compare in the gatherer
  always_ff @(posedge clk_i) begin
    row_addr_r <= row_addr_n;
    if (accept) begin
      lce_r <= lce_w_lp'(req_i.lce);
      way_r <= req_i.way;
      tag_r <= req_tag;
    end
  end

  assign row_v_o    = row_v_r;
  assign row_base_o = lce_w_lp'({cnt_i, 1'b0});
  assign lce_o      = lce_r;
  assign way_o      = way_r;
  assign tag_o      = tag_r;

  a_no_req_busy: assert property (
    @(posedge clk_i) disable iff (reset_i) busy_o |-> !req_v_i
  ) else $error("request raised while directory busy");

  a_lce_range: assert property (
    @(posedge clk_i) disable iff (reset_i) accept |-> (int'(req_i.lce) < num_lce_p)
  ) else $error("request lce %0d out of range", req_i.lce);

endmodule

// ==== dir_segment.sv ====
// directory segment top: fsm, row counter, row ram and sharers gatherer
// callers issue one request strobe at a time while busy_o is low

module dir_segment #(
  parameter int num_lce_p = 4,
  localparam int rows_lp = ((num_lce_p + 1) / 2) * dir_pkg::SETS,
  localparam int row_addr_w_lp = $clog2(rows_lp),
  localparam int cnt_w_lp = $clog2(rows_lp + 1),
  localparam int lce_w_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     req_v_i,
  input  dir_pkg::dir_req_s                        req_i,
  output logic                                     busy_o,
  output logic                                     sharers_v_o,
  output logic [num_lce_p-1:0]                     sharers_hits_o,
  output logic [num_lce_p-1:0][dir_pkg::WAY_W-1:0] sharers_ways_o,
  output dir_pkg::coh_state_e [num_lce_p-1:0]      sharers_states_o,
  output logic                                     entry_addr_v_o,
  output logic [dir_pkg::PADDR_W-1:0]              entry_addr_o
);

  import dir_pkg::*;

  // ram side
  logic                        ram_v, ram_w;
  logic [row_addr_w_lp-1:0]    ram_addr;
  dir_row_t                    ram_w_mask, ram_w_data, ram_row;

  // row counter
  logic                        cnt_clr, cnt_inc;
  logic [cnt_w_lp-1:0]         cnt;

  // gatherer controls
  logic                        clear_sharers, entry_sel, done;
  logic [TAG_SETS_PER_ROW-1:0] row_v;
  logic [lce_w_lp-1:0]         row_base, lce;
  logic [WAY_W-1:0]            way;
  logic [TAG_W-1:0]            tag;

  dir_ctrl_fsm #(.num_lce_p(num_lce_p)) fsm_i (
    .clk_i, .reset_i, .req_v_i, .req_i, .busy_o,
    .ram_v_o(ram_v), .ram_w_o(ram_w), .ram_addr_o(ram_addr),
    .ram_w_mask_o(ram_w_mask), .ram_w_data_o(ram_w_data),
    .cnt_clr_o(cnt_clr), .cnt_inc_o(cnt_inc), .cnt_i(cnt),
    .clear_o(clear_sharers), .row_v_o(row_v), .row_base_o(row_base),
    .entry_sel_o(entry_sel), .done_o(done),
    .lce_o(lce), .way_o(way), .tag_o(tag)
  );

  dir_row_counter #(.max_p(rows_lp)) counter_i (
    .clk_i, .reset_i, .clear_i(cnt_clr), .up_i(cnt_inc), .count_o(cnt)
  );

  dir_ram #(.num_lce_p(num_lce_p)) ram_i (
    .clk_i, .v_i(ram_v), .w_i(ram_w), .addr_i(ram_addr),
    .w_mask_i(ram_w_mask), .w_data_i(ram_w_data), .data_o(ram_row)
  );

  dir_sharers_gather #(.num_lce_p(num_lce_p)) gather_i (
    .clk_i, .reset_i, .row_i(ram_row), .row_v_i(row_v), .row_base_i(row_base),
    .lce_i(lce), .way_i(way), .tag_i(tag),
    .clear_i(clear_sharers), .entry_sel_i(entry_sel), .done_i(done),
    .sharers_v_o, .sharers_hits_o, .sharers_ways_o, .sharers_states_o,
    .entry_addr_v_o, .entry_addr_o
  );

endmodule

// ==== tb_dir_segment.sv ====
// self-checking testbench for the directory segment
// reads commands and expected results from dir_stim.txt with one command per line
// run from the project root so that the stim file is found

module tb_dir_segment;
  timeunit 1ns;
  timeprecision 1ps;

  import dir_pkg::*;

  localparam int num_lce_lp = 4;
  localparam int timeout_lp = 100;

  logic                             clk;
  logic                             reset;
  logic                             req_v;
  dir_req_s                         req;
  logic                             busy;
  logic                             sharers_v;
  logic [num_lce_lp-1:0]            sharers_hits;
  logic [num_lce_lp-1:0][WAY_W-1:0] sharers_ways;
  coh_state_e [num_lce_lp-1:0]      sharers_states;
  logic                             entry_addr_v;
  logic [PADDR_W-1:0]               entry_addr;

  int checks;
  int value_errs;
  int other_errs;
  bit aborted;

  dir_segment #(.num_lce_p(num_lce_lp)) dut_i (
    .clk_i(clk), .reset_i(reset), .req_v_i(req_v), .req_i(req),
    .busy_o(busy), .sharers_v_o(sharers_v), .sharers_hits_o(sharers_hits),
    .sharers_ways_o(sharers_ways), .sharers_states_o(sharers_states),
    .entry_addr_v_o(entry_addr_v), .entry_addr_o(entry_addr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // next rising edge plus 1 ns, where inputs change and outputs have settled
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic report_timeout(input string what);
    other_errs++;
    aborted = 1'b1;
    $display("ERROR gave up after %0d cycles waiting for %s", timeout_lp, what);
  endtask

  task automatic wait_busy_level(input logic level, input string what);
    int n;
    n = 0;
    while (busy !== level && n < timeout_lp) begin
      step();
      n++;
    end
    if (busy !== level) begin
      report_timeout(what);
    end
  endtask

  // entry address pulse of an rde
  task automatic wait_entry_addr(input string name);
    int n;
    n = 0;
    while (entry_addr_v !== 1'b1 && n < timeout_lp) begin
      step();
      n++;
    end
    if (entry_addr_v !== 1'b1) begin
      report_timeout({"the entry address of ", name});
    end
  endtask

  task automatic wait_sharers_valid(input string name);
    int n;
    n = 0;
    while (sharers_v !== 1'b1 && n < timeout_lp) begin
      step();
      n++;
    end
    if (sharers_v !== 1'b1) begin
      report_timeout({"the sharers result of ", name});
    end
  endtask

  // one-cycle request strobe issued once busy is low
  task automatic issue_req(input dir_cmd_e cmd, input int lce, input int way,
                           input logic [PADDR_W-1:0] addr, input coh_state_e state);
    wait_busy_level(1'b0, "busy low before a request");
    if (!aborted) begin
      req_v         = 1'b1;
      req.cmd       = cmd;
      req.lce       = LCE_ID_W'(lce);
      req.way       = WAY_W'(way);
      req.addr      = addr;
      req.coh_state = state;
      step();
      req_v = 1'b0;
    end
  endtask

  task automatic check_state(input string name, input coh_state_e exp_state,
                             input coh_state_e act_state);
    checks++;
    if (act_state !== exp_state) begin
      value_errs++;
      $display("FAIL %s state: expected %s actual %s", name, exp_state.name(),
               act_state.name());
    end
  endtask

  task automatic check_sharers(input string name,
                               input logic [num_lce_lp-1:0] exp_hits,
                               input logic [num_lce_lp-1:0][WAY_W-1:0] exp_ways,
                               input coh_state_e [num_lce_lp-1:0] exp_states);
    checks++;
    if (sharers_hits !== exp_hits) begin
      value_errs++;
      $display("FAIL %s hits: expected %b actual %b", name, exp_hits, sharers_hits);
    end
    if (sharers_ways !== exp_ways) begin
      value_errs++;
      $display("FAIL %s ways: expected %h actual %h", name, exp_ways, sharers_ways);
    end
    // states one lce at a time so a mismatch names the lce
    for (int i = 0; i < num_lce_lp; i++) begin
      check_state($sformatf("%s lce %0d", name, i), exp_states[i], sharers_states[i]);
    end
  endtask

  task automatic check_addr(input string name, input logic [PADDR_W-1:0] exp_addr,
                            input logic [PADDR_W-1:0] act_addr);
    checks++;
    if (act_addr !== exp_addr) begin
      value_errs++;
      $display("FAIL %s entry addr: expected %h actual %h", name, exp_addr, act_addr);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_flag, input logic act_flag);
    checks++;
    if (act_flag !== exp_flag) begin
      value_errs++;
      $display("FAIL %s: expected %b actual %b", name, exp_flag, act_flag);
    end
  endtask

  function automatic bit decode_cmd(input logic [31:0] txt, output dir_cmd_e cmd);
    decode_cmd = 1'b1;
    cmd = e_cmd_rdw;
    case (txt)
      "rdw": cmd = e_cmd_rdw;
      "rde": cmd = e_cmd_rde;
      "wde": cmd = e_cmd_wde;
      "wds": cmd = e_cmd_wds;
      "clr": cmd = e_cmd_clr;
      default: decode_cmd = 1'b0;
    endcase
  endfunction

  // run one stim line and compare what it returns
  task automatic run_line(input string name, input dir_cmd_e cmd, input int lce,
                          input int way, input logic [PADDR_W-1:0] addr,
                          input coh_state_e state,
                          input logic [num_lce_lp-1:0] exp_hits,
                          input logic [num_lce_lp-1:0][WAY_W-1:0] exp_ways,
                          input coh_state_e [num_lce_lp-1:0] exp_states,
                          input logic [PADDR_W-1:0] exp_addr);
    issue_req(cmd, lce, way, addr, state);
    if (!aborted) begin
      case (cmd)
        e_cmd_rdw: begin
          wait_sharers_valid(name);
          if (!aborted) begin
            check_sharers(name, exp_hits, exp_ways, exp_states);
          end
        end
        e_cmd_rde: begin
          wait_entry_addr(name);
          if (!aborted) begin
            check_addr(name, exp_addr, entry_addr);
            wait_sharers_valid(name);
          end
          // entry result sits in slot 0 and the other slots stay cleared
          if (!aborted) begin
            check_sharers(name, exp_hits, exp_ways, exp_states);
          end
        end
        default: begin
          // writes drop the previous result at the accepting edge
          check_flag({name, " sharers_v after write"}, 1'b0, sharers_v);
          // a write finishes in one cycle without raising busy
          check_flag({name, " busy after write"}, 1'b0, busy);
        end
      endcase
    end
  endtask

  initial begin
    int                               fd;
    int                               n;
    int                               line_no;
    int                               lce;
    int                               way;
    int                               state_val;
    string                            line;
    string                            name;
    logic [31:0]                      cmd_txt;
    logic [PADDR_W-1:0]               addr;
    logic [PADDR_W-1:0]               exp_addr;
    logic [num_lce_lp-1:0]            exp_hits;
    logic [2*num_lce_lp-1:0]          way_bits;
    logic [2*num_lce_lp-1:0]          state_bits;
    logic [num_lce_lp-1:0][WAY_W-1:0] exp_ways;
    coh_state_e [num_lce_lp-1:0]      exp_states;
    dir_cmd_e                         cmd;

    reset      = 1'b1;
    req_v      = 1'b0;
    req        = '0;
    checks     = 0;
    value_errs = 0;
    other_errs = 0;
    aborted    = 1'b0;
    line_no    = 0;

    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // init walk clears every row while busy is high
    wait_busy_level(1'b1, "busy to rise for the init walk");
    if (!aborted) begin
      wait_busy_level(1'b0, "the init walk to finish");
    end

    fd = $fopen("dir_stim.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("ERROR could not open dir_stim.txt");
    end else begin
      while (!aborted && !$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        line_no++;
        if (n == 0 || line.len() < 2 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %d %d %h %d %h %h %h %h", cmd_txt, lce, way, addr,
                    state_val, exp_hits, way_bits, state_bits, exp_addr);
        if (n != 9 || !decode_cmd(cmd_txt, cmd)) begin
          other_errs++;
          $display("ERROR stim line %0d cannot be parsed", line_no);
          continue;
        end
        exp_ways = way_bits;
        for (int i = 0; i < num_lce_lp; i++) begin
          exp_states[i] = coh_state_e'(state_bits[2*i +: 2]);
        end
        name = $sformatf("line %0d %s", line_no, cmd.name());
        run_line(name, cmd, lce, way, addr, coh_state_e'(state_val[1:0]),
                 exp_hits, exp_ways, exp_states, exp_addr);
      end
      $fclose(fd);
    end

    if (checks == 0) begin
      other_errs++;
      $display("ERROR no checks were run");
    end

    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs,
             other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== dir_stim.txt ====
# cmd lce way addr state | expected hits ways states entry_addr, numbers after state in hex
# ways and states hold 2 bits per lce with lce 0 lowest, unused expected columns are 0
rdw 0 0 00000 0 0 00 00 00000
rdw 0 0 00070 0 0 00 00 00000
rdw 0 0 abcd5 0 0 00 00 00000
wde 3 2 12350 2 0 00 00 00000
rde 3 2 12350 0 1 02 02 12300
rde 3 2 123d0 0 0 02 02 12300
rdw 0 0 1235f 0 8 80 80 00000
wds 3 2 12350 3 0 00 00 00000
rde 3 2 12350 0 1 02 03 12300
wds 3 2 12350 0 0 00 00 00000
rde 3 2 12350 0 0 02 00 12300
wde 0 1 02aa0 1 0 00 00 00000
wde 0 3 02aa0 3 0 00 00 00000
wde 1 0 02aa0 0 0 00 00 00000
wde 1 2 03ba0 2 0 00 00 00000
wde 2 2 02aa0 2 0 00 00 00000
wde 2 3 02aa0 3 0 00 00 00000
wde 3 0 03ba0 1 0 00 00 00000
wde 3 1 02aa0 3 0 00 00 00000
rdw 0 0 02aa7 0 d 61 e1 00000
rdw 0 0 03ba0 0 a 08 48 00000
clr 0 0 02aa0 0 0 00 00 00000
rdw 0 0 02aa0 0 c 60 e0 00000
rdw 0 0 03ba0 0 8 00 40 00000
rde 1 2 03ba0 0 0 02 00 00000
rdw 0 0 02aa0 0 c 60 e0 00000
wds 2 2 02aa0 1 0 00 00 00000
rdw 0 0 02aa0 0 c 60 d0 00000

// ==== flist.f ====
dir_pkg.sv
dir_ram.sv
dir_row_counter.sv
dir_sharers_gather.sv
dir_ctrl_fsm.sv
dir_segment.sv
tb_dir_segment.sv

// ==== Makefile ====
# build and run the directory segment testbench with Verilator
VERILATOR ?= verilator
TOP       ?= tb_dir_segment
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
